// File: zx_pager_cfg.svh
`ifndef ZX_PAGER_CFG_SVH
`define ZX_PAGER_CFG_SVH

// ========================================
// Bus widths
// ========================================

// Z80 address bus
`define ZX_CPU_AW 16

// Data bus and paging register width
`define ZX_DW 8

// Physical RAM/ROM address, 2MB space
`define ZX_PHYS_AW 21

// Offset inside one 16K slot
`define ZX_OFS_W 14

`define ZX_PAGE_RAM_W 6  // High bank bits plus 7FFD bank
`define ZX_PAGE_ROM_W 4  // ROM page select

// ========================================
// Port addresses
// ========================================

`define ZX_PORT_7FFD 16'h7ffd  // 128K paging
`define ZX_PORT_DFFD 16'hdffd  // Profi extended banks, full decode

`endif

// File: zx_pkg.sv
package zx_pkg;

	// Memory configuration, sampled at reset
	typedef enum logic [2:0] {
		std128    = 3'd0,
		pent1024  = 3'd1,
		profi1024 = 3'd2,
		std48     = 3'd3,
		plus3     = 3'd4
	} mem_mode_e;

	// 1FFD with bit 0 clear: ROM select and disk motor
	typedef struct packed {
		logic [3:0] unused_hi;
		logic       motor;    // FDC motor on
		logic       rom_hi;   // High bit of the ROM number
		logic       unused_lo;
		logic       special;
	} reg_1ffd_norm_t;

	// 1FFD with bit 0 set: all-RAM configurations
	typedef struct packed {
		logic [4:0] unused_hi;
		logic [1:0] cfg;      // One of four RAM layouts
		logic       special;
	} reg_1ffd_spec_t;

	// One register, two meanings depending on bit 0
	typedef union packed {
		logic [7:0]     word;
		reg_1ffd_norm_t norm;
		reg_1ffd_spec_t spec;
	} reg_1ffd_u;

	// Port match flags from the decoder
	typedef struct packed {
		logic p7ffd;
		logic p1ffd;
		logic pdffd;
		logic peff7;
	} port_sel_t;

endpackage

// File: page_port_if.sv
`timescale 1ns/1ps
`include "zx_pager_cfg.svh"

interface page_port_if;
	import zx_pkg::*;

	// Decoded write
	logic              wr;       // Strobe in the APB access phase
	port_sel_t         sel;
	logic              a14;      // Needed by the +3 7FFD rule
	logic [`ZX_DW-1:0] wdata;

	// Register readback
	logic [`ZX_DW-1:0] rd_7ffd;
	logic [`ZX_DW-1:0] rd_1ffd;

	modport decoder (
		output wr,
		output sel,
		output a14,
		output wdata,
		input  rd_7ffd,
		input  rd_1ffd
	);

	modport regs (
		input  wr,
		input  sel,
		input  a14,
		input  wdata,
		output rd_7ffd,
		output rd_1ffd
	);

endinterface

// File: port_decoder.sv
`timescale 1ns/1ps
`include "zx_pager_cfg.svh"

module port_decoder (
	input  logic                  clk_sys,
	input  logic                  reset,

	// APB slave
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [`ZX_CPU_AW-1:0] paddr,
	input  logic [`ZX_DW-1:0]     pwdata,
	output logic [`ZX_DW-1:0]     prdata,
	output logic                  pready,
	output logic                  pslverr,

	page_port_if.decoder          pp
);
	import zx_pkg::*;

	port_sel_t match;
	logic      any_match;
	logic      setup_phase;
	logic      access_phase;

	// ========================================
	// Partial address decode
	// ========================================

	// Same partial decode as the real machines
	always_comb begin
		match.p7ffd = ~paddr[15] & ~paddr[1];
		match.p1ffd = (paddr[15:12] == 4'b0001) & ~paddr[1];
		match.pdffd = (paddr == `ZX_PORT_DFFD);  // Profi decodes fully
		match.peff7 = (paddr[15:13] == 3'b111) & ~paddr[12] & ~paddr[3];
	end

	assign any_match    = |match;
	assign setup_phase  = psel & ~penable;
	assign access_phase = psel & penable;

	// Write strobe to the registers, lands on the access edge
	assign pp.wr    = access_phase & pwrite & any_match;
	assign pp.sel   = match;
	assign pp.a14   = paddr[14];
	assign pp.wdata = pwdata;

	// ========================================
	// APB response
	// ========================================

	// Loaded at the end of setup so that it is valid through the access phase
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pready  <= 1'b0;
			pslverr <= 1'b0;
		end else begin
			pready  <= setup_phase;               // Zero wait
			pslverr <= setup_phase & ~any_match;  // Unmapped port
		end
	end

	// Read data held until the next read
	always_ff @(posedge clk_sys) begin
		if (setup_phase && !pwrite) begin
			if (match.p1ffd)
				prdata <= pp.rd_1ffd;
			else
				prdata <= pp.rd_7ffd;
		end
	end

endmodule

// File: paging_regs.sv
`timescale 1ns/1ps
`include "zx_pager_cfg.svh"

module paging_regs (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  zx_pkg::mem_mode_e         mem_mode,

	page_port_if.regs                 pp,

	// Page state to the mapper
	output logic [`ZX_PAGE_RAM_W-1:0] page_ram,
	output logic [`ZX_PAGE_ROM_W-1:0] page_rom,
	output logic                      special,
	output logic [1:0]                special_cfg
);
	import zx_pkg::*;

	// Mode flags, only change under reset
	logic mode_p1024;
	logic mode_pf1024;
	logic mode_zx48;
	logic mode_plus3;

	logic [`ZX_DW-1:0] reg_7ffd;
	reg_1ffd_u         reg_1ffd;
	logic              eff7_mode128;  // EFF7 bit 2, back to plain 128K paging
	logic [2:0]        page_128k;     // Bank bits above the 128K range

	logic locked;
	logic wr_7ffd;
	logic wr_1ffd;

	// ========================================
	// Write qualification
	// ========================================

	// 7FFD bit 5 locks paging until reset
	assign locked = mode_zx48
		| (~mode_p1024 & reg_7ffd[5])
		| (mode_p1024 & eff7_mode128 & reg_7ffd[5]);

	// +3 needs a14 set, older machines ignore it
	assign wr_7ffd = pp.sel.p7ffd & (pp.a14 | ~mode_plus3) & ~locked;
	assign wr_1ffd = pp.sel.p1ffd & mode_plus3 & ~locked;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			reg_7ffd      <= '0;
			reg_1ffd.word <= '0;
			eff7_mode128  <= 1'b0;
			page_128k     <= '0;
			mode_p1024    <= 1'b0;
			mode_pf1024   <= 1'b0;
			mode_zx48     <= 1'b0;
			mode_plus3    <= 1'b0;
			case (mem_mode)
				pent1024:  mode_p1024  <= 1'b1;
				profi1024: mode_pf1024 <= 1'b1;
				std48:     mode_zx48   <= 1'b1;
				plus3:     mode_plus3  <= 1'b1;
				default:   ;  // std128, no extras
			endcase
		end else if (pp.wr) begin
			if (wr_7ffd) begin
				reg_7ffd <= pp.wdata;
				// Pentagon keeps its extra bank bits in 7FFD
				if (mode_p1024 && !eff7_mode128)
					page_128k <= {pp.wdata[5], pp.wdata[7:6]};
			end else if (wr_1ffd) begin
				reg_1ffd.word <= pp.wdata;
			end

			if (mode_pf1024 && pp.sel.pdffd)
				page_128k <= pp.wdata[2:0];
			if (mode_p1024 && pp.sel.peff7)
				eff7_mode128 <= pp.wdata[2];
		end
	end

	// ========================================
	// Page outputs
	// ========================================

	assign page_ram = {page_128k, reg_7ffd[2:0]};

	always_comb begin
		if (mode_plus3)
			page_rom = {2'b10, reg_1ffd.norm.rom_hi, reg_7ffd[4]};  // Four +3 ROMs
		else
			page_rom = {mode_zx48, 2'b11, mode_zx48 | reg_7ffd[4]};
	end

	// Bit 0 picks which view of 1FFD is live
	assign special     = reg_1ffd.norm.special;
	assign special_cfg = reg_1ffd.spec.cfg;

	assign pp.rd_7ffd = reg_7ffd;
	assign pp.rd_1ffd = reg_1ffd.word;

	// Lock must hold 7FFD through the next edge
	a_lock_holds_7ffd: assert property (
		@(posedge clk_sys) disable iff (reset)
		locked |=> $stable(reg_7ffd)
	);

endmodule

// File: addr_mapper.sv
`timescale 1ns/1ps
`include "zx_pager_cfg.svh"

module addr_mapper (
	input  logic                      clk_sys,
	input  logic                      reset,

	// CPU access
	input  logic                      cpu_valid,
	input  logic [`ZX_CPU_AW-1:0]     cpu_addr,
	input  logic                      cpu_write,

	// Page state
	input  logic [`ZX_PAGE_RAM_W-1:0] page_ram,
	input  logic [`ZX_PAGE_ROM_W-1:0] page_rom,
	input  logic                      special,
	input  logic [1:0]                special_cfg,

	// Translated access one cycle later
	output logic                      map_valid,
	output logic [`ZX_PHYS_AW-1:0]    ram_addr,
	output logic                      ram_we
);

	logic [1:0]             slot;
	logic [`ZX_OFS_W-1:0]   ofs;
	logic [2:0]             spec_bank;
	logic [`ZX_PHYS_AW-1:0] phys;
	logic                   we_next;

	assign slot = cpu_addr[15:14];
	assign ofs  = cpu_addr[`ZX_OFS_W-1:0];

	// All-RAM layouts of the +3
	always_comb begin
		case (slot)
			2'd0:    spec_bank = (special_cfg == 2'd0) ? 3'd0 : 3'd4;
			2'd1:    spec_bank = (special_cfg == 2'd0) ? 3'd1 :
			                     (special_cfg == 2'd3) ? 3'd7 : 3'd5;
			2'd2:    spec_bank = (special_cfg == 2'd0) ? 3'd2 : 3'd6;
			default: spec_bank = (special_cfg == 2'd1) ? 3'd7 : 3'd3;
		endcase
	end

	always_comb begin
		if (special) begin
			phys = {4'd0, spec_bank, ofs};
		end else begin
			case (slot)
				2'd0:    phys = {3'b101, page_rom, ofs};  // ROM area
				2'd1:    phys = {4'd0, 3'd5, ofs};        // Screen bank
				2'd2:    phys = {4'd0, 3'd2, ofs};
				default: phys = {1'b0, page_ram, ofs};    // Paged bank
			endcase
		end
	end

	// ROM in slot 0 is read only
	assign we_next = cpu_valid & cpu_write & (special | (slot != 2'd0));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			map_valid <= 1'b0;
			ram_we    <= 1'b0;
		end else begin
			map_valid <= cpu_valid;
			ram_we    <= we_next;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cpu_valid)
			ram_addr <= phys;
	end

	// A write never lands in the ROM half of the physical space
	a_rom_write_blocked: assert property (
		@(posedge clk_sys) disable iff (reset)
		ram_we |-> !ram_addr[`ZX_PHYS_AW-1]
	);

endmodule

// File: zx_pager.sv
`timescale 1ns/1ps
`include "zx_pager_cfg.svh"

module zx_pager (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [2:0]             mem_mode,  // Taken at reset

	// APB host port
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`ZX_CPU_AW-1:0]  paddr,
	input  logic [`ZX_DW-1:0]      pwdata,
	output logic [`ZX_DW-1:0]      prdata,
	output logic                   pready,
	output logic                   pslverr,

	// CPU side
	input  logic                   cpu_valid,
	input  logic [`ZX_CPU_AW-1:0]  cpu_addr,
	input  logic                   cpu_write,

	// Physical memory side
	output logic                   map_valid,
	output logic [`ZX_PHYS_AW-1:0] ram_addr,
	output logic                   ram_we
);
	import zx_pkg::*;

	logic [`ZX_PAGE_RAM_W-1:0] page_ram;
	logic [`ZX_PAGE_ROM_W-1:0] page_rom;
	logic                      special;
	logic [1:0]                special_cfg;

	page_port_if pp ();

	// ========================================
	// Decode, registers, mapping
	// ========================================

	port_decoder u_decoder (
		.clk_sys, .reset,
		.psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr,
		.pp      (pp.decoder)
	);

	paging_regs u_regs (
		.clk_sys, .reset,
		.mem_mode    (mem_mode_e'(mem_mode)),
		.pp          (pp.regs),
		.page_ram, .page_rom, .special, .special_cfg
	);

	addr_mapper u_mapper (
		.clk_sys, .reset,
		.cpu_valid, .cpu_addr, .cpu_write,
		.page_ram, .page_rom, .special, .special_cfg,
		.map_valid, .ram_addr, .ram_we
	);

endmodule

// File: tb_zx_pager.sv
`timescale 1ns/1ps
`include "zx_pager_cfg.svh"

module tb_zx_pager;
	import zx_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RST_CYCLES = 10;
	localparam logic [2:0] K_RST = 3'd0;
	localparam logic [2:0] K_WR = 3'd1;
	localparam logic [2:0] K_RD = 3'd2;
	localparam logic [2:0] K_CPU = 3'd3;    // Data bit 0 is the write flag
	localparam logic [2:0] K_BURST = 3'd4;  // Data is the count of random accesses

	// +3 all-RAM banks indexed by {slot, cfg}
	localparam logic [2:0] SPECIAL_BANKS [16] = '{
		3'd0, 3'd4, 3'd4, 3'd4,
		3'd1, 3'd5, 3'd5, 3'd7,
		3'd2, 3'd6, 3'd6, 3'd6,
		3'd3, 3'd7, 3'd3, 3'd3
	};

	typedef struct packed {
		logic [2:0]  test;
		logic [2:0]  kind;
		logic [2:0]  mode;
		logic [15:0] addr;
		logic [7:0]  data;
	} row_t;

	logic                   clk_sys;
	logic                   reset;
	logic [2:0]             mem_mode;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [`ZX_CPU_AW-1:0]  paddr;
	logic [`ZX_DW-1:0]      pwdata;
	logic [`ZX_DW-1:0]      prdata;
	logic                   pready;
	logic                   pslverr;
	logic                   cpu_valid;
	logic [`ZX_CPU_AW-1:0]  cpu_addr;
	logic                   cpu_write;
	logic                   map_valid;
	logic [`ZX_PHYS_AW-1:0] ram_addr;
	logic                   ram_we;

	// Reference model state
	mem_mode_e  m_mode;
	logic [7:0] m_7ffd;
	logic [7:0] m_1ffd;
	logic       m_eff7_b2;
	logic [2:0] m_high;

	row_t        rows[$];
	logic [31:0] lfsr;
	int          errors;
	int          checks;
	int          test_errors;
	int          tests;
	int          limit_cycles = 0;

	zx_pager i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// ========================================
	// Checking and reference model
	// ========================================

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("CHECK FAILED at %0d ns: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	// Galois LFSR stepped once per bit
	function automatic logic [15:0] next_rand(input int nbits);
		logic [15:0] val;
		logic        bit_out;
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			bit_out = lfsr[0];
			lfsr = bit_out ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			val = {val[14:0], bit_out};
		end
		return val;
	endfunction

	// Flags in the order 7FFD, 1FFD, DFFD, EFF7
	function automatic logic [3:0] port_match(input logic [15:0] a);
		logic p7;
		logic p1;
		logic pd;
		logic pe;
		p7 = !a[15] && !a[1];
		p1 = (a[15:12] == 4'h1) && !a[1];
		pd = (a == `ZX_PORT_DFFD);
		pe = (a[15:13] == 3'b111) && !a[12] && !a[3];
		return {p7, p1, pd, pe};
	endfunction

	task automatic clear_model(input mem_mode_e mode);
		m_mode = mode;
		m_7ffd = '0;
		m_1ffd = '0;
		m_eff7_b2 = 1'b0;
		m_high = '0;
	endtask

	task automatic update_model(input logic [15:0] a, input logic [7:0] d);
		logic [3:0] m;
		logic       lock;
		m = port_match(a);
		lock = (m_mode == std48) || (m_7ffd[5] && (m_mode != pent1024 || m_eff7_b2));
		if (m[3] && (a[14] || m_mode != plus3) && !lock) begin
			if (m_mode == pent1024 && !m_eff7_b2)
				m_high = {d[5], d[7:6]};
			m_7ffd = d;
		end
		if (m[2] && m_mode == plus3 && !lock)
			m_1ffd = d;
		if (m[1] && m_mode == profi1024)
			m_high = d[2:0];  // DFFD ignores the lock
		if (m[0] && m_mode == pent1024)
			m_eff7_b2 = d[2];
	endtask

	function automatic logic [20:0] phys_addr_of(input logic [15:0] a);
		logic [3:0]  rom;
		logic [20:0] pa;
		if (m_mode == plus3)
			rom = {2'b10, m_1ffd[2], m_7ffd[4]};
		else
			rom = {m_mode == std48, 2'b11, (m_mode == std48) || m_7ffd[4]};
		case (a[15:14])
			2'd0:    pa = {3'b101, rom, a[13:0]};
			2'd1:    pa = {7'd5, a[13:0]};
			2'd2:    pa = {7'd2, a[13:0]};
			default: pa = {1'b0, m_high, m_7ffd[2:0], a[13:0]};
		endcase
		if (m_1ffd[0])
			pa = {4'd0, SPECIAL_BANKS[{a[15:14], m_1ffd[2:1]}], a[13:0]};
		return pa;
	endfunction

	// ========================================
	// Bus tasks
	// ========================================

	task automatic apply_reset(input logic [2:0] mode);
		@(negedge clk_sys);
		reset = 1'b1;
		mem_mode = mode;
		repeat (RST_CYCLES) @(negedge clk_sys);
		reset = 1'b0;
		clear_model(mem_mode_e'(mode));
		check_value("map_valid", 32'(map_valid), 32'd0);
		check_value("ram_we", 32'(ram_we), 32'd0);
		check_value("pslverr", 32'(pslverr), 32'd0);
	endtask

	task automatic apb_xfer(input logic write, input logic [15:0] a, input logic [7:0] d);
		logic [3:0] m;
		logic [7:0] exp_rd;
		m = port_match(a);
		exp_rd = m[2] ? m_1ffd : m_7ffd;
		@(negedge clk_sys);
		psel = 1'b1;
		pwrite = write;
		paddr = a;
		pwdata = d;
		@(negedge clk_sys);
		penable = 1'b1;
		// The slave has no wait states
		check_value("pready", 32'(pready), 32'd1);
		check_value("pslverr", 32'(pslverr), 32'(m == 4'd0));
		if (!write)
			check_value("prdata", 32'(prdata), 32'(exp_rd));
		if (write)
			update_model(a, d);
		@(negedge clk_sys);  // Access edge has passed
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	// Back to back accesses with each result due one cycle later
	task automatic cpu_burst(input int n, input logic use_rand, input logic [15:0] a,
		input logic w);
		logic [15:0] rbits;
		logic [20:0] exp_addr;
		logic        exp_we;
		exp_addr = '0;
		exp_we = 1'b0;
		for (int i = 0; i <= n; i++) begin
			@(negedge clk_sys);
			check_value("map_valid", 32'(map_valid), 32'(i > 0));
			if (i > 0) begin
				check_value("ram_addr", 32'(ram_addr), 32'(exp_addr));
				check_value("ram_we", 32'(ram_we), 32'(exp_we));
			end
			cpu_valid = (i < n);
			if (i < n) begin
				cpu_addr = use_rand ? next_rand(16) : a;
				rbits = use_rand ? next_rand(1) : {15'd0, w};
				cpu_write = rbits[0];
				exp_addr = phys_addr_of(cpu_addr);
				exp_we = cpu_write && (m_1ffd[0] || cpu_addr[15:14] != 2'd0);
			end
		end
		cpu_write = 1'b0;
		@(negedge clk_sys);
		check_value("map_valid", 32'(map_valid), 32'd0);
	endtask

	// ========================================
	// Stimulus table
	// ========================================

	task automatic add_row(input int test, input logic [2:0] kind, input logic [2:0] mode,
		input logic [15:0] addr, input logic [7:0] data);
		row_t r;
		r.test = 3'(test);
		r.kind = kind;
		r.mode = mode;
		r.addr = addr;
		r.data = data;
		rows.push_back(r);
	endtask

	task automatic build_table();
		add_row(1, K_RST, std128, 16'h0000, 8'h00);
		add_row(1, K_RD, std128, `ZX_PORT_7FFD, 8'h00);
		for (int b = 0; b < 8; b++) begin
			add_row(1, K_WR, std128, `ZX_PORT_7FFD, 8'(b));
			add_row(1, K_CPU, std128, 16'hc123, 8'h00);
			add_row(1, K_RD, std128, `ZX_PORT_7FFD, 8'h00);
		end
		add_row(1, K_CPU, std128, 16'h4321, 8'h01);
		add_row(1, K_CPU, std128, 16'h8321, 8'h01);
		add_row(1, K_CPU, std128, 16'h0321, 8'h00);
		add_row(2, K_RST, std128, 16'h0000, 8'h00);
		add_row(2, K_WR, std128, `ZX_PORT_7FFD, 8'h23);  // Bank 3 with the lock bit
		add_row(2, K_WR, std128, `ZX_PORT_7FFD, 8'h16);
		add_row(2, K_CPU, std128, 16'hc000, 8'h00);
		add_row(2, K_CPU, std128, 16'h0000, 8'h00);
		add_row(2, K_RD, std128, `ZX_PORT_7FFD, 8'h00);
		add_row(2, K_RST, std128, 16'h0000, 8'h00);
		add_row(2, K_WR, std128, `ZX_PORT_7FFD, 8'h06);
		add_row(2, K_CPU, std128, 16'hc000, 8'h00);
		add_row(3, K_RST, plus3, 16'h0000, 8'h00);
		add_row(3, K_WR, plus3, `ZX_PORT_7FFD, 8'h03);
		add_row(3, K_WR, plus3, 16'h3ffd, 8'h07);  // Ignored on +3 with a14 low
		add_row(3, K_CPU, plus3, 16'hc000, 8'h00);
		for (int r = 0; r < 4; r++) begin
			add_row(3, K_WR, plus3, 16'h1ffd, 8'({r[1], 2'b00}));
			add_row(3, K_WR, plus3, `ZX_PORT_7FFD, 8'({r[0], 4'h3}));
			add_row(3, K_CPU, plus3, 16'h0042, 8'h00);
			add_row(3, K_RD, plus3, 16'h1ffd, 8'h00);
		end
		for (int c = 0; c < 4; c++) begin
			add_row(3, K_WR, plus3, 16'h1ffd, 8'({c[1:0], 1'b1}));
			for (int s = 0; s < 4; s++)
				add_row(3, K_CPU, plus3, {s[1:0], 14'h0abc}, 8'h01);
		end
		add_row(3, K_WR, plus3, 16'h1ffd, 8'h00);
		add_row(3, K_CPU, plus3, 16'h0abc, 8'h01);
		add_row(4, K_RST, pent1024, 16'h0000, 8'h00);
		add_row(4, K_WR, pent1024, `ZX_PORT_7FFD, 8'he1);
		add_row(4, K_CPU, pent1024, 16'hc000, 8'h00);
		add_row(4, K_WR, pent1024, `ZX_PORT_7FFD, 8'h42);
		add_row(4, K_CPU, pent1024, 16'hc000, 8'h00);
		add_row(4, K_WR, pent1024, 16'heff7, 8'h04);  // Back to 128K paging
		add_row(4, K_WR, pent1024, `ZX_PORT_7FFD, 8'hc3);
		add_row(4, K_CPU, pent1024, 16'hc000, 8'h00);
		add_row(4, K_WR, pent1024, `ZX_PORT_7FFD, 8'h25);
		add_row(4, K_WR, pent1024, `ZX_PORT_7FFD, 8'h01);
		add_row(4, K_RD, pent1024, `ZX_PORT_7FFD, 8'h00);
		add_row(4, K_WR, pent1024, 16'heff7, 8'h00);
		add_row(4, K_WR, pent1024, `ZX_PORT_7FFD, 8'h86);
		add_row(4, K_CPU, pent1024, 16'hc000, 8'h00);
		add_row(4, K_RST, profi1024, 16'h0000, 8'h00);
		add_row(4, K_WR, profi1024, `ZX_PORT_DFFD, 8'h05);
		add_row(4, K_WR, profi1024, `ZX_PORT_7FFD, 8'h02);
		add_row(4, K_CPU, profi1024, 16'hc000, 8'h00);
		add_row(4, K_WR, profi1024, `ZX_PORT_7FFD, 8'h20);
		add_row(4, K_WR, profi1024, `ZX_PORT_DFFD, 8'h03);
		add_row(4, K_WR, profi1024, `ZX_PORT_7FFD, 8'h07);
		add_row(4, K_CPU, profi1024, 16'hc000, 8'h00);
		add_row(5, K_RST, std128, 16'h0000, 8'h00);
		for (int s = 0; s < 4; s++)
			add_row(5, K_CPU, std128, {s[1:0], 14'h0100}, 8'h01);
		add_row(5, K_RST, std48, 16'h0000, 8'h00);
		add_row(5, K_WR, std48, `ZX_PORT_7FFD, 8'h17);
		add_row(5, K_RD, std48, `ZX_PORT_7FFD, 8'h00);
		add_row(5, K_CPU, std48, 16'h0000, 8'h01);
		add_row(5, K_CPU, std48, 16'hc000, 8'h00);
		add_row(6, K_RST, std128, 16'h0000, 8'h00);
		add_row(6, K_WR, std128, 16'h8001, 8'h55);
		add_row(6, K_RD, std128, 16'hfffe, 8'h00);
		add_row(6, K_WR, std128, 16'h7fff, 8'h07);
		add_row(6, K_RD, std128, 16'hdffc, 8'h00);
		add_row(6, K_BURST, std128, 16'h0000, 8'd8);
		add_row(6, K_WR, std128, `ZX_PORT_7FFD, 8'h04);
		add_row(6, K_BURST, std128, 16'h0000, 8'd12);
		add_row(6, K_RST, plus3, 16'h0000, 8'h00);
		add_row(6, K_WR, plus3, 16'h1ffd, 8'h03);
		add_row(6, K_BURST, plus3, 16'h0000, 8'd8);
	endtask

	function automatic string test_name(input logic [2:0] t);
		case (t)
			3'd1:    return "128K banks and readback";
			3'd2:    return "7FFD lock";
			3'd3:    return "+3 ROMs and all-RAM layouts";
			3'd4:    return "Pentagon and Profi extended banks";
			3'd5:    return "ROM write protect and 48K";
			default: return "Unmapped ports and CPU bursts";
		endcase
	endfunction

	// ========================================
	// Main sequence and watchdog
	// ========================================

	initial begin
		row_t r;
		int   cycles;
		reset = 1'b1;
		mem_mode = std128;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		cpu_valid = 1'b0;
		cpu_addr = '0;
		cpu_write = 1'b0;
		lfsr = 32'hae54;
		errors = 0;
		checks = 0;
		test_errors = 0;
		tests = 0;
		build_table();
		cycles = RST_CYCLES + 4;
		foreach (rows[i]) begin
			cycles += 4;
			if (rows[i].kind == K_RST)
				cycles += RST_CYCLES;
			if (rows[i].kind == K_BURST)
				cycles += int'(rows[i].data);
		end
		limit_cycles = cycles;
		repeat (RST_CYCLES) @(negedge clk_sys);
		reset = 1'b0;
		for (int i = 0; i < rows.size(); i++) begin
			r = rows[i];
			case (r.kind)
				K_RST:   apply_reset(r.mode);
				K_WR:    apb_xfer(1'b1, r.addr, r.data);
				K_RD:    apb_xfer(1'b0, r.addr, 8'h00);
				K_CPU:   cpu_burst(1, 1'b0, r.addr, r.data[0]);
				default: cpu_burst(int'(r.data), 1'b1, 16'h0000, 1'b0);
			endcase
			if (i == rows.size() - 1 || rows[i + 1].test != r.test) begin
				$display("Test %0d, %s: %s", r.test, test_name(r.test),
					(test_errors == 0) ? "ok" : "errors found");
				test_errors = 0;
				tests++;
			end
		end
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		wait (limit_cycles > 0);
		#(limit_cycles * CLK_PERIOD);
		$display("Watchdog timeout after %0d cycles, the tests did not finish", limit_cycles);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+.
zx_pkg.sv
page_port_if.sv
port_decoder.sv
paging_regs.sv
addr_mapper.sv
zx_pager.sv
tb_zx_pager.sv

// File: Makefile
TOP = tb_zx_pager

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
